/* project.f */
src/mic_meter_pkg.sv
src/display_if.sv
src/i2s_mic_receiver.sv
src/level_meter.sv
src/seven_seg_scanner.sv
src/mic_meter_top.sv
tb/mic_meter_asserts.sv
tb/tb_mic_meter.sv

/* run.sh */
#!/bin/sh
# verilator build and run of the mic meter testbench

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mic_meter -f project.f -o tb_mic_meter \
    && ./obj_dir/tb_mic_meter +verilator+error+limit+1000 > "$log" 2>&1 \
    || { cat "$log" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$log"

grep -q "Regression failed" "$log" \
    && { echo "simulation reported failure"; exit 1; } \
    || exit 0

/* tb/tb_mic_meter.sv */
`timescale 1ns/1ps

module tb_mic_meter
    import mic_meter_pkg::*;
();

    localparam int clk_period  = 8;
    localparam int num_frames  = 200;
    localparam int frame_bits  = 2 * slot_bits;  // sck periods per frame
    localparam int frame_clks  = frame_bits * 2 * sck_half;
    localparam int watchdog_ns = num_frames * frame_clks * clk_period * 6 / 5;

    logic       clk;
    logic       reset;
    logic [1:0] key;
    logic       mic_sd;
    logic       mic_sck;
    logic       mic_ws;
    led_t       led;
    segs_t      abcdefgh;
    digit_t     digit;

    // --------------------
    // model state

    sample_t frame_sample;   // word sent in the current left slot
    int      model_peak;
    logic    model_clip;
    int      pos;            // sck period within the frame
    int      mid_right_cnt;  // frames that reached the middle of the right slot
    int      edge_cnt;       // clk edges since reset went low
    logic    mic_in_reset;
    logic    sck_seen;
    logic    ws_seen;
    logic    sck_fell;

    int led_errors;
    int segs_errors;
    int digit_errors;
    int frame_errors;

    mic_meter_top DUT
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .key      ( key      ),
        .mic_sd   ( mic_sd   ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    // serial pins, ready strobe and digit enables all meet at the top
    bind mic_meter_top mic_meter_asserts i_asserts
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .sample_ready ( sample_ready ),
        .digit        ( digit        )
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk)
    begin
        if (reset)
            edge_cnt = 0;
        else
            edge_cnt = edge_cnt + 1;
    end

    // --------------------
    // reference functions

    // bit n of each mask is set when hex digit n lights that segment
    function automatic segs_t hex_segments(input nibble_t n);
        logic [15:0] seg_a = 16'hd7ed;
        logic [15:0] seg_b = 16'h279f;
        logic [15:0] seg_c = 16'h2ffb;
        logic [15:0] seg_d = 16'h7b6d;
        logic [15:0] seg_e = 16'hfd45;
        logic [15:0] seg_f = 16'hdf71;
        logic [15:0] seg_g = 16'hef7c;
        return {seg_a[n], seg_b[n], seg_c[n], seg_d[n], seg_e[n], seg_f[n], seg_g[n], 1'b0};
    endfunction

    function automatic led_t expected_led();
        int level;
        level = (model_peak >> 12) & 7;
        return {model_clip, 7'((1 << level) - 1)};  // thermometer under the clip led
    endfunction

    function automatic segs_t expected_segs(input int d);
        if (d > 0 && model_peak < (1 << (4 * d)))
            return '0;  // leading zero
        return hex_segments(nibble_t'(model_peak >> (4 * d)));
    endfunction

    task automatic pick_sample;
        sample_t r;
        r = sample_t'($urandom);
        r = r >>> $urandom_range(15, 0);  // spread the levels
        if ($urandom_range(7, 0) == 0)
            r[w_sample - 1 -: w_level] = $urandom_range(1, 0) ? 16'h7fff : 16'h8000;
        frame_sample = r;
    endtask

    task automatic apply_sample(input sample_t s);
        int top;
        int mag;
        top = int'(s) >>> (w_sample - w_level);
        mag = (top < 0) ? -top : top;
        if (mag > 32767)
            mag = 32767;
        if (top == 32767 || top == -32768)
            model_clip = 1'b1;
        if (mag > model_peak)
            model_peak = mag;
    endtask

    // --------------------
    // microphone model

    always @(posedge clk)
    begin
        mic_in_reset = reset;
        #1;
        if (mic_in_reset)
        begin
            pos      = 0;
            sck_seen = 1'b0;
            ws_seen  = 1'b0;
        end
        else
        begin
            sck_fell = sck_seen && !mic_sck;
            if (mic_ws !== ws_seen && !sck_fell)
            begin
                frame_errors++;
                $display("mic_ws changed at %0t while mic_sck did not fall", $time);
            end
            if (sck_fell)
            begin
                pos = (pos + 1) % frame_bits;
                if (mic_ws !== (pos >= slot_bits))
                begin
                    frame_errors++;
                    $display("mic_ws has the wrong level in sck period %0d at %0t", pos, $time);
                end
                if (pos == 0)
                    pick_sample();
                if (pos == slot_bits)
                    apply_sample(frame_sample);  // the whole left word is in by now
                if (pos >= 1 && pos <= w_sample)
                    mic_sd = frame_sample[w_sample - pos];  // msb first after the delay bit
                else
                    mic_sd = 1'($urandom);
                if (pos == slot_bits + slot_bits / 2)
                    mid_right_cnt++;
            end
            sck_seen = mic_sck;
            ws_seen  = mic_ws;
        end
    end

    // --------------------
    // checks

    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic check_led(input led_t expected, input led_t actual);
        if (actual !== expected)
        begin
            led_errors++;
            $display("Error: led expected %h actual %h at %0t", expected, actual, $time);
        end
    endtask

    task automatic check_segs(input segs_t expected, input segs_t actual);
        if (actual !== expected)
        begin
            segs_errors++;
            $display("Error: abcdefgh expected %h actual %h at %0t", expected, actual, $time);
        end
    endtask

    task automatic check_digit(input digit_t expected, input digit_t actual);
        if (actual !== expected)
        begin
            digit_errors++;
            $display("Error: digit expected %h actual %h at %0t", expected, actual, $time);
        end
    endtask

    // one pass over all digits, sampled in the middle of each
    task automatic check_display_scan;
        int d;
        while (((edge_cnt - 1) % scan_div) != scan_div / 2)
            step();
        for (int i = 0; i < w_digit; i++)
        begin
            d = ((edge_cnt - 1) / scan_div) % w_digit;
            check_digit(digit_t'(1 << d), digit);
            check_segs(expected_segs(d), abcdefgh);
            if (i < w_digit - 1)
                repeat (scan_div) step();
        end
    endtask

    task automatic clear_meter;
        key[0] = 1'b1;
        step();
        key[0]     = 1'b0;
        model_peak = 0;
        model_clip = 1'b0;
        step();  // led follows one edge later
        check_led(expected_led(), led);
    endtask

    initial
    begin
        int   asserts;
        logic do_clear;

        void'($urandom(32'h80d1));
        clk           = 1'b0;
        reset         = 1'b1;
        key           = '0;
        mic_sd        = 1'b0;
        model_peak    = 0;
        model_clip    = 1'b0;
        mid_right_cnt = 0;
        led_errors    = 0;
        segs_errors   = 0;
        digit_errors  = 0;
        frame_errors  = 0;
        pick_sample();

        repeat (16) step();
        check_led('0, led);
        check_digit(digit_t'(1), digit);
        check_segs(hex_segments(4'h0), abcdefgh);
        if (mic_sck !== 1'b0 || mic_ws !== 1'b0)
        begin
            frame_errors++;
            $display("mic_sck or mic_ws is not low during reset");
        end
        reset = 1'b0;

        for (int f = 0; f < num_frames; f++)
        begin
            wait (mid_right_cnt == f + 1);
            do_clear = ($urandom_range(5, 0) == 0);
            check_led(expected_led(), led);
            check_display_scan();
            if (do_clear)
                clear_meter();  // lands before the next ready strobe
        end

        asserts = DUT.i_asserts.fail_count;
        $display("errors: led %0d, segments %0d, digit %0d, framing %0d, assertions %0d",
                 led_errors, segs_errors, digit_errors, frame_errors, asserts);
        if (led_errors + segs_errors + digit_errors + frame_errors + asserts == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(watchdog_ns);
        $display("timeout after %0d ns before all frames were checked", watchdog_ns);
        $display("Regression failed");
        $finish;
    end

endmodule

/* tb/mic_meter_asserts.sv */
`timescale 1ns/1ps

module mic_meter_asserts
    import mic_meter_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   sck,
    input logic   ws,
    input logic   sample_ready,
    input digit_t digit
);

    int fail_count = 0;  // read by the testbench at the end

    digit_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(digit))
    else
    begin
        $error("digit enable %b is not one-hot", digit);
        fail_count++;
    end

    // ready is a single cycle strobe
    ready_single: assert property (@(posedge clk) disable iff (reset)
        !(sample_ready && $past(sample_ready)))
    else
    begin
        $error("sample_ready high in two cycles in a row");
        fail_count++;
    end

    ws_on_sck_fall: assert property (@(posedge clk) disable iff (reset)
        $changed(ws) |-> $fell(sck))  // ws moves with the falling sck only
    else
    begin
        $error("ws changed without a falling sck");
        fail_count++;
    end

endmodule

/* src/mic_meter_top.sv */
`timescale 1ns/1ps

module mic_meter_top
    import mic_meter_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic [1:0] key,       // key[0] clears the meter, key[1] spare

    input  logic       mic_sd,
    output logic       mic_sck,
    output logic       mic_ws,

    output led_t       led,
    output segs_t      abcdefgh,
    output digit_t     digit
);

    sample_t sample;
    logic    sample_ready;

    display_if disp ();

    // --------------------

    i2s_mic_receiver i_receiver
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .sd           ( mic_sd       ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .sample       ( sample       ),
        .sample_ready ( sample_ready )
    );

    level_meter i_meter
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .sample       ( sample       ),
        .sample_ready ( sample_ready ),
        .clear        ( key [0]      ),
        .disp         ( disp         )
    );

    seven_seg_scanner i_scanner
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .disp         ( disp         ),
        .led          ( led          ),
        .abcdefgh     ( abcdefgh     ),
        .digit        ( digit        )
    );

endmodule

/* src/seven_seg_scanner.sv */
`timescale 1ns/1ps

module seven_seg_scanner
    import mic_meter_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    display_if.sink disp,
    output led_t    led,
    output segs_t   abcdefgh,
    output digit_t  digit
);

    logic [w_scan - 1:0] scan_cnt;
    logic [w_sel  - 1:0] sel;     // active digit
    nibble_t             nibble;
    segs_t               font;

    // segments active high, a is the msb
    function automatic segs_t hex_font(input nibble_t n);
        case (n)
            4'h0: hex_font = 8'b1111_1100;
            4'h1: hex_font = 8'b0110_0000;
            4'h2: hex_font = 8'b1101_1010;
            4'h3: hex_font = 8'b1111_0010;
            4'h4: hex_font = 8'b0110_0110;
            4'h5: hex_font = 8'b1011_0110;
            4'h6: hex_font = 8'b1011_1110;
            4'h7: hex_font = 8'b1110_0000;
            4'h8: hex_font = 8'b1111_1110;
            4'h9: hex_font = 8'b1111_0110;
            4'ha: hex_font = 8'b1110_1110;
            4'hb: hex_font = 8'b0011_1110;
            4'hc: hex_font = 8'b1001_1100;
            4'hd: hex_font = 8'b0111_1010;
            4'he: hex_font = 8'b1001_1110;
            default: hex_font = 8'b1000_1110;  // f
        endcase
    endfunction

    // --------------------
    // scan timing

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            scan_cnt <= '0;
            sel      <= '0;
        end
        else if (scan_cnt == w_scan'(scan_div - 1))
        begin
            scan_cnt <= '0;
            sel      <= sel + 1'b1;  // 3 wraps back to 0
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // --------------------
    // outputs

    assign nibble = disp.peak[{sel, 2'b00} +: 4];
    assign font   = hex_font(nibble);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            digit    <= digit_t'(1);
            abcdefgh <= hex_font(4'h0);  // peak is zero after reset
            led      <= '0;
        end
        else
        begin
            digit    <= digit_t'(1) << sel;
            abcdefgh <= disp.blank[sel] ? '0 : font;
            led      <= {disp.clip, disp.bar};  // clip on the top led
        end
    end

endmodule

/* src/level_meter.sv */
`timescale 1ns/1ps

module level_meter
    import mic_meter_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  sample_t   sample,
    input  logic      sample_ready,
    input  logic      clear,
    display_if.source disp
);

    logic signed [w_level - 1:0] top;
    level_t                      mag;
    logic                        full_scale;
    level_t                      peak;
    logic                        clip;

    // --------------------
    // magnitude of the top bits

    assign top = sample[w_sample - 1 -: w_level];

    assign full_scale = (level_t'(top) == level_max) || (level_t'(top) == level_min);

    always_comb
    begin
        if (!top[w_level - 1])
            mag = level_t'(top);
        else if (level_t'(top) == level_min)
            mag = level_max;  // most negative value has no positive twin
        else
            mag = level_t'(-top);
    end

    // --------------------
    // peak hold and clip

    // clear wins over a sample in the same cycle
    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            peak <= '0;
            clip <= 1'b0;
        end
        else if (sample_ready)
        begin
            if (mag > peak)
                peak <= mag;

            if (full_scale)
                clip <= 1'b1;  // sticky until clear
        end
    end

    // --------------------
    // display values

    assign disp.peak = peak;
    assign disp.clip = clip;

    // bar k lights once peak[14:12] goes above k
    always_comb
    begin
        for (int k = 0; k < w_led - 1; k++)
            disp.bar[k] = (int'(peak[w_level - 2 -: 3]) > k);
    end

    // digit d is blank when it and every digit above it are zero
    always_comb
    begin
        disp.blank = '0;

        for (int d = 1; d < w_digit; d++)
            disp.blank[d] = ((peak >> (4 * d)) == '0);
    end

endmodule

/* src/i2s_mic_receiver.sv */
`timescale 1ns/1ps

module i2s_mic_receiver
    import mic_meter_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    sd,
    output logic    sck,
    output logic    ws,
    output sample_t sample,
    output logic    sample_ready
);

    logic [w_div     - 1:0] div_cnt;
    logic [w_frame   - 1:0] bit_cnt;    // sck period within the frame
    logic [w_frame   - 1:0] bit_cnt_next;
    logic [w_bit_idx - 1:0] bit_idx;    // data bit within the sample
    logic [w_sample  - 2:0] shift_reg;
    logic                   div_wrap;
    logic                   sck_rise;
    logic                   sck_fall;
    i2s_state_t             state;

    // --------------------
    // serial clock

    assign div_wrap = (div_cnt == w_div'(sck_half - 1));
    assign sck_rise = div_wrap && !sck;
    assign sck_fall = div_wrap && sck;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;  // starts low
        end
        else if (div_wrap)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // --------------------
    // frame position and word select

    assign bit_cnt_next = bit_cnt + 1'b1;

    // ws moves with sck falling, low for the left slot
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bit_cnt <= '0;
            ws      <= 1'b0;
        end
        else if (sck_fall)
        begin
            bit_cnt <= bit_cnt_next;
            ws      <= bit_cnt_next[w_frame - 1];
        end
    end

    // --------------------
    // capture of the left slot

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= idle_s;
            bit_idx      <= '0;
            sample_ready <= 1'b0;
        end
        else
        begin
            sample_ready <= 1'b0;

            case (state)
                idle_s:
                    if (!ws && bit_cnt == '0)
                        state <= delay_s;

                delay_s:
                    if (sck_rise)  // this bit carries no data
                    begin
                        state   <= shift_s;
                        bit_idx <= '0;
                    end

                shift_s:
                    if (sck_rise)
                    begin
                        if (bit_idx == w_bit_idx'(w_sample - 1))
                        begin
                            state        <= skip_s;
                            sample_ready <= 1'b1;  // one cycle after the lsb
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end

                skip_s:
                    if (ws)  // right slot is ignored
                        state <= idle_s;

                default:
                    state <= idle_s;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise && state == shift_s)
        begin
            shift_reg <= {shift_reg[w_sample - 3:0], sd};  // msb first

            if (bit_idx == w_bit_idx'(w_sample - 1))
                sample <= {shift_reg, sd};
        end
    end

endmodule

/* src/display_if.sv */
`timescale 1ns/1ps

// meter state as seen by the display side
interface display_if
    import mic_meter_pkg::*;
();

    level_t              peak;   // held peak magnitude
    logic [w_led - 2:0]  bar;    // thermometer of the peak
    logic                clip;   // full scale seen since clear
    digit_t              blank;  // leading zero digits, bit 0 never set

    modport source
    (
        output peak,
        output bar,
        output clip,
        output blank
    );

    modport sink
    (
        input  peak,
        input  bar,
        input  clip,
        input  blank
    );

endinterface

/* src/mic_meter_pkg.sv */
package mic_meter_pkg;

    // --------------------
    // widths

    localparam int w_sample = 24;  // microphone word
    localparam int w_level  = 16;  // top sample bits used by the meter
    localparam int w_led    = 8;
    localparam int w_digit  = 4;

    // --------------------
    // timing

    localparam int sck_half  = 4;   // clk cycles per sck half period
    localparam int slot_bits = 32;  // sck periods per channel slot
    localparam int scan_div  = 64;  // clk cycles each digit stays lit

    // counter widths
    localparam int w_div     = $clog2(sck_half);
    localparam int w_frame   = $clog2(2 * slot_bits);  // msb tells the slot
    localparam int w_bit_idx = $clog2(w_sample);
    localparam int w_scan    = $clog2(scan_div);
    localparam int w_sel     = $clog2(w_digit);

    // --------------------
    // types

    typedef logic signed [w_sample - 1:0] sample_t;
    typedef logic        [w_level  - 1:0] level_t;  // peak magnitude, tops out at 7fff
    typedef logic        [w_led    - 1:0] led_t;
    typedef logic        [w_digit  - 1:0] digit_t;  // one-hot digit enable
    typedef logic        [7:0]            segs_t;   // a is the top bit
    typedef logic        [3:0]            nibble_t;

    localparam level_t level_max = {1'b0, {(w_level - 1){1'b1}}};  // 7fff
    localparam level_t level_min = {1'b1, {(w_level - 1){1'b0}}};  // 8000

    typedef enum logic [1:0]
    {
        idle_s,   // waiting for the left slot
        delay_s,  // one sck period after the ws edge
        shift_s,
        skip_s    // rest of the frame
    } i2s_state_t;

endpackage
